// File: Bender.yml
package:
  name: full_permutation

sources:
  - src/permPkg.sv
  - src/syncFifo.sv
  - src/roundRobinDivider.sv
  - src/permutationLane.sv
  - src/topManager.sv
  - src/laneArray.sv
  - src/fullPermutationTop.sv
  - target: simulation
    files:
      - verif/permTb.sv

// File: src.f
src/permPkg.sv
src/syncFifo.sv
src/roundRobinDivider.sv
src/permutationLane.sv
src/topManager.sv
src/laneArray.sv
src/fullPermutationTop.sv
verif/permTb.sv

// File: src/fullPermutationTop.sv
`timescale 1ns/10ps

module fullPermutationTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inValid,
    input  logic                            startNewTop,
    input  permPkg::hostWord_t              inData,
    input  logic                            outReady,
    output logic                            inReady,
    output logic                            outValid,
    output logic [permPkg::WORD_WIDTH-1:0]  results
);

    logic holdOff;
    logic [$clog2(permPkg::RESET_HOLD_CYCLES)-1:0] holdCount;
    logic coreReset;
    permPkg::botPair_t bots;
    logic accept;
    logic botWrite;
    logic topWrite;
    logic laneAlmostFull;
    logic laneEmpty;
    logic stall;
    logic [permPkg::WORD_WIDTH-1:0] currentTop;
    logic resultValid;
    permPkg::resultWord_t laneResult;
    permPkg::resultWord_t outWord;
    logic outAlmostFull;
    logic outEmpty;
    logic slowDown;

    // Internal reset held for a while after rst falls
    always_ff @(posedge clk) begin
        if (rst) begin
            holdCount <= '0;
            holdOff <= 1'b1;
        end else if (holdOff) begin
            if (holdCount == permPkg::RESET_HOLD_CYCLES - 1) begin
                holdOff <= 1'b0;
            end else begin
                holdCount <= holdCount + 1'b1;
            end
        end
    end

    // Sub-blocks stay in reset while rst is high and through the hold-off
    assign coreReset = rst || holdOff;

    // Split the host word into the two channel halves
    assign bots.botA = {inData.upper[127:64], inData.lower[127:64]};
    assign bots.botB = {inData.upper[63:0], inData.lower[63:0]};

    assign inReady = !holdOff && !laneAlmostFull && !stall;
    assign accept = inValid && inReady;
    assign botWrite = accept && !startNewTop;
    // A top command reuses botA as the new top
    assign topWrite = accept && startNewTop;

    always_ff @(posedge clk) begin
        if (coreReset) begin
            slowDown <= 1'b0;
        end else begin
            slowDown <= outAlmostFull;
        end
    end

    topManager topMgr (
        .clk(clk),
        .rst(coreReset),
        .topWrite(topWrite),
        .topIn(bots.botA),
        .pipelineEmpty(laneEmpty),
        .slowDown(slowDown),
        .stall(stall),
        .currentTop(currentTop)
    );

    laneArray lanes (
        .clk(clk),
        .rst(coreReset),
        .writeBot(botWrite),
        .bots(bots),
        .currentTop(currentTop),
        .slowDown(slowDown),
        .almostFull(laneAlmostFull),
        .empty(laneEmpty),
        .resultValid(resultValid),
        .result(laneResult)
    );

    syncFifo #(
        .WIDTH($bits(permPkg::resultWord_t)),
        .DEPTH_LOG2(permPkg::OUT_FIFO_DEPTH_LOG2),
        .ALMOST_FULL_MARGIN(permPkg::OUT_FIFO_MARGIN)
    ) outFifo (
        .clk(clk),
        .rst(coreReset),
        .writeEnable(resultValid),
        .dataIn(laneResult),
        .readEnable(outReady && !outEmpty),
        .dataOut(outWord),
        .empty(outEmpty),
        .almostFull(outAlmostFull)
    );

    assign outValid = !outEmpty;
    assign results = {{(permPkg::WORD_WIDTH - $bits(permPkg::resultWord_t)){1'b0}}, outWord};

endmodule

// File: src/laneArray.sv
`timescale 1ns/10ps

module laneArray (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            writeBot,
    input  permPkg::botPair_t               bots,
    input  logic [permPkg::WORD_WIDTH-1:0]  currentTop,
    input  logic                            slowDown,
    output logic                            almostFull,
    output logic                            empty,
    output logic                            resultValid,
    output permPkg::resultWord_t            result
);

    logic [permPkg::LANES_PER_CHANNEL-1:0] selectA;
    logic [permPkg::LANES_PER_CHANNEL-1:0] selectB;
    logic [permPkg::LANE_COUNT-1:0] laneWrites;
    logic [permPkg::LANE_COUNT-1:0] laneAlmostFulls;
    logic [permPkg::LANE_COUNT-1:0] laneEmpties;
    logic [permPkg::LANE_COUNT-1:0] laneReads;
    logic [permPkg::LANE_COUNT-1:0] originSelect;
    permPkg::laneResult_t laneResults [permPkg::LANE_COUNT];
    permPkg::laneResult_t mergedA;
    permPkg::laneResult_t mergedB;
    logic originEmpty;
    logic originAlmostFull;
    logic popJob;
    logic [1:0] popDelay;
    logic [$clog2(permPkg::EMPTY_IDLE_CYCLES + 1)-1:0] idleCycles;

    roundRobinDivider #(.WIDTH(permPkg::LANES_PER_CHANNEL)) dividerA (
        .clk(clk),
        .rst(rst),
        .accept(writeBot),
        .almostFulls(laneAlmostFulls[permPkg::LANES_PER_CHANNEL-1:0]),
        .selectedOneHot(selectA)
    );

    roundRobinDivider #(.WIDTH(permPkg::LANES_PER_CHANNEL)) dividerB (
        .clk(clk),
        .rst(rst),
        .accept(writeBot),
        .almostFulls(laneAlmostFulls[permPkg::LANE_COUNT-1:permPkg::LANES_PER_CHANNEL]),
        .selectedOneHot(selectB)
    );

    // Channel A lanes sit in the low bits, channel B above
    assign laneWrites = writeBot ? {selectB, selectA} : '0;

    for (genvar i = 0; i < permPkg::LANE_COUNT; i++) begin : gLane
        permutationLane lane (
            .clk(clk),
            .rst(rst),
            .writeBot(laneWrites[i]),
            .bot(i < permPkg::LANES_PER_CHANNEL ? bots.botA : bots.botB),
            .currentTop(currentTop),
            .readRequest(laneReads[i]),
            .almostFull(laneAlmostFulls[i]),
            .empty(laneEmpties[i]),
            .result(laneResults[i])
        );
    end

    // Which lanes got each job, in input order
    syncFifo #(
        .WIDTH(permPkg::LANE_COUNT),
        .DEPTH_LOG2(permPkg::ORIGIN_DEPTH_LOG2),
        .ALMOST_FULL_MARGIN(permPkg::LANE_FIFO_MARGIN)
    ) originQueue (
        .clk(clk),
        .rst(rst),
        .writeEnable(writeBot),
        .dataIn({selectB, selectA}),
        .readEnable(popJob),
        .dataOut(originSelect),
        .empty(originEmpty),
        .almostFull(originAlmostFull)
    );

    // Pop only once every lane named by the head entry has its result ready
    assign popJob = !originEmpty && (&(~originSelect | ~laneEmpties)) && !slowDown;
    assign laneReads = popJob ? originSelect : '0;

    always_comb begin
        mergedA = '0;
        mergedB = '0;
        for (int i = 0; i < permPkg::LANES_PER_CHANNEL; i++) begin
            mergedA = mergedA | laneResults[i];
            mergedB = mergedB | laneResults[permPkg::LANES_PER_CHANNEL + i];
        end
    end

    always_ff @(posedge clk) begin
        result.resultA <= mergedA;
        result.resultB <= mergedB;
    end

    // Lane read register, then output register
    always_ff @(posedge clk) begin
        if (rst) begin
            popDelay <= '0;
        end else begin
            popDelay <= {popDelay[0], popJob};
        end
    end

    assign resultValid = popDelay[1];

    assign almostFull = (&laneAlmostFulls[permPkg::LANES_PER_CHANNEL-1:0])
        || (&laneAlmostFulls[permPkg::LANE_COUNT-1:permPkg::LANES_PER_CHANNEL])
        || originAlmostFull;

    // Conservative empty, covers results still in the read path
    always_ff @(posedge clk) begin
        if (rst) begin
            idleCycles <= '0;
        end else if (writeBot || !originEmpty) begin
            idleCycles <= '0;
        end else if (!empty) begin
            idleCycles <= idleCycles + 1'b1;
        end
    end

    assign empty = (idleCycles == permPkg::EMPTY_IDLE_CYCLES);

endmodule

// File: src/permPkg.sv
package permPkg;

    // Lane organisation
    localparam int LANE_COUNT = 4;
    localparam int LANES_PER_CHANNEL = LANE_COUNT / 2;

    localparam int WORD_WIDTH = 128;
    localparam int LANE_LATENCY = 6;

    // Buffer sizing
    localparam int LANE_FIFO_DEPTH_LOG2 = 5;
    localparam int LANE_FIFO_MARGIN = 8;
    localparam int ORIGIN_DEPTH_LOG2 = 7;
    localparam int OUT_FIFO_DEPTH_LOG2 = 5;
    localparam int OUT_FIFO_MARGIN = 6;

    localparam int RESET_HOLD_CYCLES = 35;
    localparam int EMPTY_IDLE_CYCLES = 15;

    // Result field widths
    localparam int COUNT_WIDTH = 13;
    localparam int SUM_WIDTH = 48;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] upper;
        logic [WORD_WIDTH-1:0] lower;
    } hostWord_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] botA;
        logic [WORD_WIDTH-1:0] botB;
    } botPair_t;

    typedef struct packed {
        logic [COUNT_WIDTH-1:0] pcoeffCount;
        logic [SUM_WIDTH-1:0] pcoeffSum;
    } laneResult_t;

    typedef struct packed {
        laneResult_t resultA;
        laneResult_t resultB;
    } resultWord_t;

    typedef enum logic [1:0] {
        TOP_RUN,
        TOP_DRAIN,
        TOP_INSTALL
    } topState_e;

endpackage

// File: src/permutationLane.sv
`timescale 1ns/10ps

module permutationLane (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            writeBot,
    input  logic [permPkg::WORD_WIDTH-1:0]  bot,
    input  logic [permPkg::WORD_WIDTH-1:0]  currentTop,
    input  logic                            readRequest,
    output logic                            almostFull,
    output logic                            empty,
    output permPkg::laneResult_t            result
);

    function automatic logic [permPkg::COUNT_WIDTH-1:0] countOnes(
        input logic [permPkg::WORD_WIDTH-1:0] value
    );
        logic [permPkg::COUNT_WIDTH-1:0] total;
        total = '0;
        for (int i = 0; i < permPkg::WORD_WIDTH; i++) begin
            total = total + value[i];
        end
        return total;
    endfunction

    permPkg::laneResult_t computed;
    permPkg::laneResult_t stageData [permPkg::LANE_LATENCY];
    logic [permPkg::LANE_LATENCY-1:0] stageValid;
    permPkg::laneResult_t fifoHead;

    // Stand-in for the real permutation core
    assign computed.pcoeffCount = countOnes(bot & currentTop);
    assign computed.pcoeffSum = bot[permPkg::SUM_WIDTH-1:0] ^ currentTop[permPkg::SUM_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[permPkg::LANE_LATENCY-2:0], writeBot};
        end
    end

    always_ff @(posedge clk) begin
        stageData[0] <= computed;
        for (int i = 1; i < permPkg::LANE_LATENCY; i++) begin
            stageData[i] <= stageData[i-1];
        end
    end

    // Last stage lands in the FIFO exactly LANE_LATENCY cycles after the write
    syncFifo #(
        .WIDTH($bits(permPkg::laneResult_t)),
        .DEPTH_LOG2(permPkg::LANE_FIFO_DEPTH_LOG2),
        .ALMOST_FULL_MARGIN(permPkg::LANE_FIFO_MARGIN)
    ) resultFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(stageValid[permPkg::LANE_LATENCY-1]),
        .dataIn(stageData[permPkg::LANE_LATENCY-1]),
        .readEnable(readRequest),
        .dataOut(fifoHead),
        .empty(empty),
        .almostFull(almostFull)
    );

    // Zero when not read so channel results can be ORed
    always_ff @(posedge clk) begin
        result <= readRequest ? fifoHead : '0;
    end

endmodule

// File: src/roundRobinDivider.sv
`timescale 1ns/10ps

module roundRobinDivider #(
    parameter int WIDTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             accept,
    input  logic [WIDTH-1:0] almostFulls,
    output logic [WIDTH-1:0] selectedOneHot
);

    logic [WIDTH-1:0] nextOneHot;
    logic [WIDTH-1:0] candidate;

    // Walk from the farthest lane back to the nearest, so the nearest free one wins
    always_comb begin
        nextOneHot = selectedOneHot;
        candidate = selectedOneHot;
        for (int i = WIDTH - 1; i > 0; i--) begin
            candidate = (selectedOneHot << i) | (selectedOneHot >> (WIDTH - i));
            if (|(candidate & ~almostFulls)) begin
                nextOneHot = candidate;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            selectedOneHot <= WIDTH'(1);
        end else if (accept) begin
            // Stays in place when every other lane is almost full
            selectedOneHot <= nextOneHot;
        end
    end

endmodule

// File: src/syncFifo.sv
`timescale 1ns/10ps

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 5,
    parameter int ALMOST_FULL_MARGIN = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             writeEnable,
    input  logic [WIDTH-1:0] dataIn,
    input  logic             readEnable,
    output logic [WIDTH-1:0] dataOut,
    output logic             empty,
    output logic             almostFull
);

    logic [WIDTH-1:0] mem [1 << DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;
    // One extra bit so a completely full FIFO is representable
    logic [DEPTH_LOG2:0] count;
    logic doWrite;
    logic doRead;

    assign doWrite = writeEnable && !count[DEPTH_LOG2];
    assign doRead = readEnable && !empty;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doRead) begin
                readPtr <= readPtr + 1'b1;
            end
            if (doWrite && !doRead) begin
                count <= count + 1'b1;
            end else if (doRead && !doWrite) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry is always visible
    assign dataOut = mem[readPtr];
    assign empty = (count == '0);
    // Fewer than ALMOST_FULL_MARGIN free slots left
    assign almostFull = count > ((1 << DEPTH_LOG2) - ALMOST_FULL_MARGIN);

endmodule

// File: src/topManager.sv
`timescale 1ns/10ps

module topManager (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            topWrite,
    input  logic [permPkg::WORD_WIDTH-1:0]  topIn,
    input  logic                            pipelineEmpty,
    input  logic                            slowDown,
    output logic                            stall,
    output logic [permPkg::WORD_WIDTH-1:0]  currentTop
);

    permPkg::topState_e state;
    logic [permPkg::WORD_WIDTH-1:0] pendingTop;

    always_ff @(posedge clk) begin
        if (topWrite && state == permPkg::TOP_RUN) begin
            pendingTop <= topIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= permPkg::TOP_RUN;
            currentTop <= '0;
        end else begin
            case (state)
                permPkg::TOP_RUN: begin
                    if (topWrite) begin
                        state <= permPkg::TOP_DRAIN;
                    end
                end
                permPkg::TOP_DRAIN: begin
                    // Every lane and the reassembly path must be quiet
                    if (pipelineEmpty && !slowDown) begin
                        state <= permPkg::TOP_INSTALL;
                    end
                end
                permPkg::TOP_INSTALL: begin
                    currentTop <= pendingTop;
                    state <= permPkg::TOP_RUN;
                end
                default: begin
                    state <= permPkg::TOP_RUN;
                end
            endcase
        end
    end

    assign stall = (state != permPkg::TOP_RUN);

endmodule

// File: verif/permTb.sv
`timescale 1ns/10ps

module permTb;

    logic clk;
    logic rst;
    logic inValid;
    logic startNewTop;
    permPkg::hostWord_t inData;
    logic outReady;
    logic inReady;
    logic outValid;
    logic [permPkg::WORD_WIDTH-1:0] results;

    int valueErrors = 0;
    int otherErrors = 0;
    string testName = "reset";
    logic [31:0] lfsrState = 32'd17;

    // Reference model state
    permPkg::resultWord_t expectedQueue [$];
    logic [permPkg::WORD_WIDTH-1:0] modelTop = '0;
    logic [permPkg::WORD_WIDTH-1:0] expectedResults = '0;
    logic expectedAvailable = 1'b0;
    int bottomsAccepted = 0;
    int outputsConsumed = 0;
    int edgesSinceReset = 0;
    logic holdWindow;

    fullPermutationTop UUT (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .startNewTop(startNewTop),
        .inData(inData),
        .outReady(outReady),
        .inReady(inReady),
        .outValid(outValid),
        .results(results)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [127:0] randomBits(input int count);
        logic [127:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits = {bits[126:0], lfsrState[0]};
        end
        return bits;
    endfunction

    function automatic permPkg::hostWord_t randomWord();
        permPkg::hostWord_t word;
        word.upper = randomBits(permPkg::WORD_WIDTH);
        word.lower = randomBits(permPkg::WORD_WIDTH);
        return word;
    endfunction

    // Channel A takes the upper halves, channel B the lower halves
    function automatic permPkg::botPair_t splitWord(input permPkg::hostWord_t word);
        permPkg::botPair_t pair;
        pair.botA = {word.upper[127:64], word.lower[127:64]};
        pair.botB = {word.upper[63:0], word.lower[63:0]};
        return pair;
    endfunction

    function automatic permPkg::laneResult_t laneRule(
        input logic [permPkg::WORD_WIDTH-1:0] bot,
        input logic [permPkg::WORD_WIDTH-1:0] top
    );
        permPkg::laneResult_t res;
        logic [permPkg::WORD_WIDTH-1:0] masked;
        masked = bot & top;
        res.pcoeffCount = '0;
        for (int i = 0; i < permPkg::WORD_WIDTH; i++) begin
            if (masked[i]) begin
                res.pcoeffCount = res.pcoeffCount + 1'b1;
            end
        end
        res.pcoeffSum = bot[permPkg::SUM_WIDTH-1:0] ^ top[permPkg::SUM_WIDTH-1:0];
        return res;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            edgesSinceReset <= 0;
        end else if (edgesSinceReset < 1000) begin
            edgesSinceReset <= edgesSinceReset + 1;
        end
    end

    assign holdWindow = rst || (edgesSinceReset < permPkg::RESET_HOLD_CYCLES);

    // Scoreboard bookkeeping, inputs and outputs are stable at the falling edge
    always @(negedge clk) begin : scoreboard
        permPkg::botPair_t pair;
        permPkg::resultWord_t entry;
        if (!rst) begin
            if (outValid && outReady) begin
                outputsConsumed++;
                if (expectedQueue.size() > 0) begin
                    void'(expectedQueue.pop_front());
                end
            end
            if (inValid && inReady) begin
                pair = splitWord(inData);
                if (startNewTop) begin
                    modelTop = pair.botA;
                end else begin
                    entry.resultA = laneRule(pair.botA, modelTop);
                    entry.resultB = laneRule(pair.botB, modelTop);
                    expectedQueue.push_back(entry);
                    bottomsAccepted++;
                end
            end
            expectedAvailable = (expectedQueue.size() > 0);
            if (expectedAvailable) begin
                expectedResults = {{(permPkg::WORD_WIDTH - $bits(permPkg::resultWord_t)){1'b0}},
                    expectedQueue[0]};
            end
        end
    end

    resetHold: assert property (@(negedge clk) holdWindow |-> (!inReady && !outValid))
    else begin
        valueErrors++;
        $display("Error: %s expected inReady 0 outValid 0 actual %b %b",
            testName, $sampled(inReady), $sampled(outValid));
    end

    // Every consumed word must match the model head in order
    outputOrder: assert property (@(negedge clk) disable iff (rst)
        (outValid && outReady) |-> (expectedAvailable && results == expectedResults))
    else begin
        valueErrors++;
        $display("Error: %s expected %h actual %h",
            testName, $sampled(expectedResults), $sampled(results));
    end

    outputHeld: assert property (@(negedge clk) disable iff (rst)
        (outValid && !outReady) |=> outValid)
    else begin
        valueErrors++;
        $display("Error: %s expected outValid 1 actual %b", testName, $sampled(outValid));
    end

    topStall: assert property (@(negedge clk) disable iff (rst)
        (inValid && inReady && startNewTop) |=> !inReady)
    else begin
        valueErrors++;
        $display("Error: %s expected inReady 0 actual %b", testName, $sampled(inReady));
    end

    task automatic sendWord(input logic isTop, input permPkg::hostWord_t word, input int limit);
        int waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        inValid = 1'b1;
        startNewTop = isTop;
        inData = word;
        while (!taken && waited < limit) begin
            @(negedge clk);
            taken = inReady;
            @(posedge clk);
            #1;
            waited++;
        end
        inValid = 1'b0;
        startNewTop = 1'b0;
        if (!taken) begin
            otherErrors++;
            $display("%s: the DUT never accepted an input word", testName);
        end
    endtask

    task automatic waitReady(input int limit);
        int waited;
        logic ready;
        waited = 0;
        ready = 1'b0;
        while (!ready && waited < limit) begin
            @(negedge clk);
            ready = inReady;
            @(posedge clk);
            #1;
            waited++;
        end
        if (!ready) begin
            otherErrors++;
            $display("%s: inReady never rose after reset", testName);
        end
    endtask

    // Keep offering bottoms until the DUT pushes back
    task automatic offerUntilStall(input int limit);
        int offered;
        logic stalled;
        offered = 0;
        stalled = 1'b0;
        while (!stalled && offered < limit) begin
            inValid = 1'b1;
            startNewTop = 1'b0;
            inData = randomWord();
            @(negedge clk);
            stalled = !inReady;
            @(posedge clk);
            #1;
            offered++;
        end
        inValid = 1'b0;
        if (!stalled) begin
            otherErrors++;
            $display("%s: inReady never fell while outputs were blocked", testName);
        end
    endtask

    task automatic waitDrain(input int limit);
        int waited;
        logic drained;
        waited = 0;
        drained = 1'b0;
        while (!drained && waited < limit) begin
            @(posedge clk);
            #1;
            drained = (expectedQueue.size() == 0) && !outValid;
            waited++;
        end
        if (!drained) begin
            otherErrors++;
            $display("%s: expected results never all arrived", testName);
        end
    endtask

    task automatic checkCounts();
        assert (outputsConsumed == bottomsAccepted)
        else begin
            valueErrors++;
            $display("Error: %s expected %0d outputs actual %0d",
                testName, bottomsAccepted, outputsConsumed);
        end
    endtask

    initial begin
        rst = 1'b1;
        inValid = 1'b0;
        startNewTop = 1'b0;
        inData = '0;
        outReady = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        waitReady(permPkg::RESET_HOLD_CYCLES + 20);

        testName = "zeroTop";
        outReady = 1'b1;
        repeat (8) sendWord(1'b0, randomWord(), 200);
        waitDrain(500);
        checkCounts();

        testName = "stream";
        sendWord(1'b1, randomWord(), 200);
        repeat (200) sendWord(1'b0, randomWord(), 200);
        waitDrain(1000);
        checkCounts();

        // Outputs blocked long enough to back up into the lanes
        testName = "backPressure";
        outReady = 1'b0;
        offerUntilStall(400);
        repeat (40) @(posedge clk);
        #1;
        outReady = 1'b1;
        waitDrain(1000);
        checkCounts();

        testName = "topChange";
        repeat (20) sendWord(1'b0, randomWord(), 200);
        sendWord(1'b1, randomWord(), 200);
        repeat (20) sendWord(1'b0, randomWord(), 200);
        waitDrain(1000);
        checkCounts();

        $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
